/* design/video_defines.svh */
// Widths, latencies and BT.601 full-range coefficients for the video output path
// Include wherever a width, latency or coefficient is needed
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Pixel component and transmitter word widths
`define VIDEO_COLOR_DEPTH 8
`define VIDEO_TXD_WIDTH 16

// Register stages in each block
`define CSC_LATENCY 5
`define PACK_LATENCY 1

// Luma weights in 1/256 units, all added
`define CSC_Y_R 8'd77
`define CSC_Y_G 8'd150
`define CSC_Y_B 8'd29

// Blue difference, R and G terms subtracted
`define CSC_CB_R 8'd43
`define CSC_CB_G 8'd85
`define CSC_CB_B 8'd128

// Red difference, G and B terms subtracted
`define CSC_CR_R 8'd128
`define CSC_CR_G 8'd107
`define CSC_CR_B 8'd21

// Mid-scale offset for both chroma results
`define CSC_CHROMA_OFFSET 128

`endif

/* design/video_pkg.sv */
// Pixel and sync types shared by the video output path
// Import into module bodies, or use scoped names in port lists
`include "video_defines.svh"

package video_pkg;

  ////////////////////
  // Pixel formats
  ////////////////////

  // One RGB pixel as delivered by the timing source
  typedef struct packed {
    logic [`VIDEO_COLOR_DEPTH-1:0] r;
    logic [`VIDEO_COLOR_DEPTH-1:0] g;
    logic [`VIDEO_COLOR_DEPTH-1:0] b;
  } rgb_pixel_t;

  // Full-range 4:4:4 result of the converter
  typedef struct packed {
    logic [`VIDEO_COLOR_DEPTH-1:0] y;
    logic [`VIDEO_COLOR_DEPTH-1:0] cb;
    logic [`VIDEO_COLOR_DEPTH-1:0] cr;
  } ycbcr_pixel_t;

  ////////////////////
  // Sync levels
  ////////////////////

  // Polarity is passed through untouched
  typedef struct packed {
    logic vsync;
    logic hsync;
  } video_sync_t;

endpackage

/* design/video_delay_line.sv */
// Fixed-depth shift register for any packed payload type
// Used for the sync levels at the top and for data enable inside the converter
module video_delay_line #(
  parameter int  DEPTH     = 1,
  parameter type payload_t = logic
) (
  input  logic     video_clk_148,
  input  logic     video_reset_148,
  input  payload_t i_data,
  output payload_t o_data
);

  payload_t stage_q [DEPTH];

  ////////////////////
  // Shift chain
  ////////////////////

  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        stage_q[i] <= '0;
      end
    end
    else
    begin
      stage_q[0] <= i_data;
      // Each stage takes the one before it
      for (int i = 1; i < DEPTH; i++)
      begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign o_data = stage_q[DEPTH-1];

endmodule

/* design/rgb_to_ycbcr.sv */
// Five-stage pipelined RGB to full-range YCbCr converter
// Accepts one pixel per clock; o_de follows i_de with the same latency as the data
`include "video_defines.svh"

module rgb_to_ycbcr (
  input  logic                    video_clk_148,
  input  logic                    video_reset_148,
  input  video_pkg::rgb_pixel_t   i_rgb,
  input  logic                    i_de,
  output video_pkg::ycbcr_pixel_t o_ycbcr,
  output logic                    o_de
);
  import video_pkg::*;

  localparam int DW        = `VIDEO_COLOR_DEPTH;
  localparam int COEF_W    = 8;
  localparam int FRAC_BITS = 8;
  localparam int PROD_W    = DW + COEF_W;
  localparam int SUM_W     = PROD_W + 2;
  localparam logic signed [SUM_W-1:0] CHROMA_OFS = SUM_W'(`CSC_CHROMA_OFFSET);
  localparam logic signed [SUM_W-1:0] PIX_MAX    = SUM_W'((1 << DW) - 1);

  rgb_pixel_t              rgb_q;
  logic [PROD_W-1:0]       y_prod_q [3];
  logic [PROD_W-1:0]       cb_prod_q [3];
  logic [PROD_W-1:0]       cr_prod_q [3];
  logic signed [SUM_W-1:0] y_sum_q;
  logic signed [SUM_W-1:0] cb_sum_q;
  logic signed [SUM_W-1:0] cr_sum_q;
  logic signed [SUM_W-1:0] y_ofs_q;
  logic signed [SUM_W-1:0] cb_ofs_q;
  logic signed [SUM_W-1:0] cr_ofs_q;

  function automatic logic [PROD_W-1:0] mul(input logic [DW-1:0] pix,
                                            input logic [COEF_W-1:0] coef);
    return PROD_W'(pix) * PROD_W'(coef);
  endfunction

  // Products are unsigned, widen before signed arithmetic
  function automatic logic signed [SUM_W-1:0] ext(input logic [PROD_W-1:0] p);
    return $signed(SUM_W'(p));
  endfunction

  function automatic logic [DW-1:0] clamp(input logic signed [SUM_W-1:0] v);
    if (v[SUM_W-1])
      return '0;
    else if (v > PIX_MAX)
      return '1;
    else
      return v[DW-1:0];
  endfunction

  ////////////////////
  // Stages 1 and 2
  ////////////////////

  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      rgb_q     <= '0;
      y_prod_q  <= '{default: '0};
      cb_prod_q <= '{default: '0};
      cr_prod_q <= '{default: '0};
    end
    else
    begin
      rgb_q        <= i_rgb;
      y_prod_q[0]  <= mul(rgb_q.r, `CSC_Y_R);
      y_prod_q[1]  <= mul(rgb_q.g, `CSC_Y_G);
      y_prod_q[2]  <= mul(rgb_q.b, `CSC_Y_B);
      cb_prod_q[0] <= mul(rgb_q.r, `CSC_CB_R);
      cb_prod_q[1] <= mul(rgb_q.g, `CSC_CB_G);
      cb_prod_q[2] <= mul(rgb_q.b, `CSC_CB_B);
      cr_prod_q[0] <= mul(rgb_q.r, `CSC_CR_R);
      cr_prod_q[1] <= mul(rgb_q.g, `CSC_CR_G);
      cr_prod_q[2] <= mul(rgb_q.b, `CSC_CR_B);
    end
  end

  ////////////////////
  // Stages 3 to 5
  ////////////////////

  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      y_sum_q  <= '0;
      cb_sum_q <= '0;
      cr_sum_q <= '0;
      y_ofs_q  <= '0;
      cb_ofs_q <= '0;
      cr_ofs_q <= '0;
      o_ycbcr  <= '0;
    end
    else
    begin
      y_sum_q    <= ext(y_prod_q[0]) + ext(y_prod_q[1]) + ext(y_prod_q[2]);
      cb_sum_q   <= ext(cb_prod_q[2]) - ext(cb_prod_q[0]) - ext(cb_prod_q[1]);
      cr_sum_q   <= ext(cr_prod_q[0]) - ext(cr_prod_q[1]) - ext(cr_prod_q[2]);
      // Arithmetic shift keeps negative chroma sums negative
      y_ofs_q    <= y_sum_q >>> FRAC_BITS;
      cb_ofs_q   <= (cb_sum_q >>> FRAC_BITS) + CHROMA_OFS;
      cr_ofs_q   <= (cr_sum_q >>> FRAC_BITS) + CHROMA_OFS;
      o_ycbcr.y  <= clamp(y_ofs_q);
      o_ycbcr.cb <= clamp(cb_ofs_q);
      o_ycbcr.cr <= clamp(cr_ofs_q);
    end
  end

  // Data enable rides beside the arithmetic
  video_delay_line #(
    .DEPTH     (`CSC_LATENCY),
    .payload_t (logic)
  ) de_delay_i (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_data          (i_de),
    .o_data          (o_de)
  );

endmodule

/* design/ycbcr_422_packer.sv */
// Packs 4:4:4 YCbCr into 16-bit 4:2:2 words for the HDMI transmitter
// Chroma alternates Cb then Cr within each active run; one register stage
`include "video_defines.svh"

module ycbcr_422_packer (
  input  logic                          video_clk_148,
  input  logic                          video_reset_148,
  input  video_pkg::ycbcr_pixel_t       i_ycbcr,
  input  logic                          i_de,
  output logic [`VIDEO_TXD_WIDTH-1:0]   o_txd,
  output logic                          o_de
);

  localparam int DW = `VIDEO_COLOR_DEPTH;

  // Low on even pixels of a run, high on odd
  logic          phase_q;
  logic [DW-1:0] chroma;

  assign chroma = phase_q ? i_ycbcr.cr : i_ycbcr.cb;

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      phase_q <= 1'b0;
      o_txd   <= '0;
      o_de    <= 1'b0;
    end
    else
    begin
      o_de <= i_de;
      if (i_de)
      begin
        phase_q <= ~phase_q;
        // Chroma in the upper byte, luma in the lower byte
        o_txd   <= {chroma, i_ycbcr.y};
      end
      else
      begin
        // Blanking restarts the pairing at Cb
        phase_q <= 1'b0;
        o_txd   <= '0;
      end
    end
  end

endmodule

/* design/hdmi_ycbcr_top.sv */
// Video output path: RGB in, 16-bit YCbCr 4:2:2 out for the HDMI transmitter
// Data, data enable and sync all leave six clocks after they enter
`include "video_defines.svh"

module hdmi_ycbcr_top (
  input  logic                        video_clk_148,
  input  logic                        video_reset_148,
  input  video_pkg::rgb_pixel_t       i_rgb,
  input  logic                        i_de,
  input  video_pkg::video_sync_t      i_sync,
  output logic [`VIDEO_TXD_WIDTH-1:0] o_txd,
  output logic                        o_de,
  output video_pkg::video_sync_t      o_sync
);

  video_pkg::ycbcr_pixel_t csc_ycbcr;
  logic                    csc_de;

  ////////////////////
  // Color conversion
  ////////////////////

  rgb_to_ycbcr rgb_to_ycbcr_i (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_rgb           (i_rgb),
    .i_de            (i_de),
    .o_ycbcr         (csc_ycbcr),
    .o_de            (csc_de)
  );

  ycbcr_422_packer ycbcr_422_packer_i (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_ycbcr         (csc_ycbcr),
    .i_de            (csc_de),
    .o_txd           (o_txd),
    .o_de            (o_de)
  );

  ////////////////////
  // Sync alignment
  ////////////////////

  // Matches converter plus packer latency
  video_delay_line #(
    .DEPTH     (`CSC_LATENCY + `PACK_LATENCY),
    .payload_t (video_pkg::video_sync_t)
  ) sync_delay_i (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_data          (i_sync),
    .o_data          (o_sync)
  );

endmodule

/* bench/tb_hdmi_ycbcr_top.sv */
// Self-checking testbench for the HDMI YCbCr output path
// Drives LCG pixel runs and sync toggles and checks every output against a six-cycle model
`include "video_defines.svh"

module tb_hdmi_ycbcr_top;
  import video_pkg::*;

  localparam int DW             = `VIDEO_COLOR_DEPTH;
  localparam int TXD_W          = `VIDEO_TXD_WIDTH;
  localparam int PIPE_DEPTH     = `CSC_LATENCY + `PACK_LATENCY;
  localparam int TIMEOUT_CYCLES = 5000;
  localparam int MIN_ACTIVE     = 1000;

  // What the outputs should hold once a sampled input has travelled through
  typedef struct packed {
    logic             de;
    video_sync_t      sync;
    logic [TXD_W-1:0] txd;
  } expect_t;

  logic             video_clk_148;
  logic             video_reset_148;
  rgb_pixel_t       i_rgb;
  logic             i_de;
  video_sync_t      i_sync;
  logic [TXD_W-1:0] o_txd;
  logic             o_de;
  video_sync_t      o_sync;

  logic [31:0] lcg_state = 32'h0e44c9dd;
  video_sync_t sync_state;
  expect_t     exp_pipe [PIPE_DEPTH];
  logic        model_phase;
  logic        checks_on;
  int          cycle_count = 0;
  int          active_checked;
  string       test_name;
  rgb_pixel_t  corner [8];

  hdmi_ycbcr_top hdmi_ycbcr_top_i (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_rgb           (i_rgb),
    .i_de            (i_de),
    .i_sync          (i_sync),
    .o_txd           (o_txd),
    .o_de            (o_de),
    .o_sync          (o_sync)
  );

  initial
  begin
    video_clk_148 = 1'b0;
    forever #5 video_clk_148 = ~video_clk_148;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic rgb_pixel_t random_pixel();
    logic [31:0] r;
    rgb_pixel_t  px;
    r    = next_rand();
    px.r = r[31:24];
    px.g = r[23:16];
    px.b = r[15:8];
    return px;
  endfunction

  function automatic logic [DW-1:0] limit_byte(input int v);
    if (v < 0)
      return '0;
    else if (v > 255)
      return '1;
    else
      return v[DW-1:0];
  endfunction

  // Full-range conversion in plain integers
  // Shift by 8 is arithmetic on int
  function automatic ycbcr_pixel_t expected_ycbcr(input rgb_pixel_t px);
    int           r;
    int           g;
    int           b;
    int           y_val;
    int           cb_val;
    int           cr_val;
    ycbcr_pixel_t res;
    r      = int'(px.r);
    g      = int'(px.g);
    b      = int'(px.b);
    y_val  = (int'(`CSC_Y_R) * r + int'(`CSC_Y_G) * g + int'(`CSC_Y_B) * b) >>> 8;
    cb_val = ((int'(`CSC_CB_B) * b - int'(`CSC_CB_R) * r - int'(`CSC_CB_G) * g) >>> 8)
             + `CSC_CHROMA_OFFSET;
    cr_val = ((int'(`CSC_CR_R) * r - int'(`CSC_CR_G) * g - int'(`CSC_CR_B) * b) >>> 8)
             + `CSC_CHROMA_OFFSET;
    res.y  = limit_byte(y_val);
    res.cb = limit_byte(cb_val);
    res.cr = limit_byte(cr_val);
    return res;
  endfunction

  task automatic check_value(input string label, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("[FAIL] %s %s expected 0x%0h actual 0x%0h", test_name, label, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "Output mismatch");
    end
  endtask

  // One clock of stimulus with occasional sync toggles
  task automatic drive_cycle(input rgb_pixel_t rgb, input logic de, input logic rst);
    logic [31:0] r;
    r = next_rand();
    if (r[31:28] == 4'd0)
      sync_state.hsync = ~sync_state.hsync;
    if (r[27:22] == 6'd0)
      sync_state.vsync = ~sync_state.vsync;
    @(posedge video_clk_148);
    video_reset_148 <= rst;
    i_rgb           <= rgb;
    i_de            <= de;
    i_sync          <= sync_state;
  endtask

  task automatic run_corner_tests();
    for (int i = 0; i < 8; i++)
      drive_cycle(corner[i], 1'b1, 1'b0);
    repeat (2) drive_cycle(random_pixel(), 1'b0, 1'b0);
    // Odd-length run
    for (int i = 0; i < 5; i++)
      drive_cycle(corner[i], 1'b1, 1'b0);
    drive_cycle(random_pixel(), 1'b0, 1'b0);
    // Single-pixel runs must all carry Cb
    for (int i = 0; i < 8; i++)
    begin
      drive_cycle(corner[i], 1'b1, 1'b0);
      drive_cycle(random_pixel(), 1'b0, 1'b0);
    end
  endtask

  task automatic run_random_stream(input int cycles);
    int          driven;
    int          run_len;
    int          blank_len;
    logic [31:0] r;
    driven = 0;
    while (driven < cycles)
    begin
      r       = next_rand();
      run_len = 1 + int'(r[31:24] % 8'd40);
      if (r[23:21] == 3'd0)
        run_len = 1;
      blank_len = 1 + int'(r[20:18]);
      repeat (run_len) drive_cycle(random_pixel(), 1'b1, 1'b0);
      repeat (blank_len) drive_cycle(random_pixel(), 1'b0, 1'b0);
      driven = driven + run_len + blank_len;
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Sees the inputs as the DUT samples them before this edge's drives land
  always @(posedge video_clk_148)
  begin : model_update
    expect_t      entry;
    ycbcr_pixel_t pix;
    checks_on = 1'b1;
    pix       = expected_ycbcr(i_rgb);
    if (video_reset_148)
    begin
      for (int i = 0; i < PIPE_DEPTH; i++)
        exp_pipe[i] = '0;
      model_phase = 1'b0;
    end
    else
    begin
      entry.de   = i_de;
      entry.sync = i_sync;
      if (i_de)
      begin
        entry.txd   = {(model_phase ? pix.cr : pix.cb), pix.y};
        model_phase = ~model_phase;
      end
      else
      begin
        entry.txd   = '0;
        model_phase = 1'b0;
      end
      for (int i = PIPE_DEPTH - 1; i > 0; i--)
        exp_pipe[i] = exp_pipe[i-1];
      exp_pipe[0] = entry;
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge video_clk_148)
  begin
    if (checks_on)
    begin
      check_value("de", {31'd0, exp_pipe[PIPE_DEPTH-1].de}, {31'd0, o_de});
      check_value("sync", {30'd0, exp_pipe[PIPE_DEPTH-1].sync}, {30'd0, o_sync});
      check_value("luma", {24'd0, exp_pipe[PIPE_DEPTH-1].txd[DW-1:0]}, {24'd0, o_txd[DW-1:0]});
      check_value("chroma", {24'd0, exp_pipe[PIPE_DEPTH-1].txd[TXD_W-1:DW]},
                  {24'd0, o_txd[TXD_W-1:DW]});
      if (exp_pipe[PIPE_DEPTH-1].de)
        active_checked++;
    end
  end

  always @(posedge video_clk_148)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation timed out");
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial
  begin
    video_reset_148 = 1'b1;
    i_rgb           = '0;
    i_de            = 1'b0;
    i_sync          = '0;
    sync_state      = '0;
    model_phase     = 1'b0;
    checks_on       = 1'b0;
    active_checked  = 0;
    // Black, white, primaries and secondaries
    corner[0] = 24'h000000;
    corner[1] = 24'hffffff;
    corner[2] = 24'hff0000;
    corner[3] = 24'h00ff00;
    corner[4] = 24'h0000ff;
    corner[5] = 24'hffff00;
    corner[6] = 24'h00ffff;
    corner[7] = 24'hff00ff;

    // Reset spans ten edges counting the one held by the initial value
    test_name = "reset";
    repeat (9) drive_cycle(random_pixel(), 1'b1, 1'b1);
    test_name = "reset_release";
    repeat (8) drive_cycle(random_pixel(), 1'b1, 1'b0);

    test_name = "corners";
    run_corner_tests();

    test_name = "random_runs";
    run_random_stream(3000);

    test_name = "mid_reset";
    repeat (10) drive_cycle(random_pixel(), 1'b1, 1'b0);
    repeat (3) drive_cycle(random_pixel(), 1'b1, 1'b1);
    repeat (7) drive_cycle(random_pixel(), 1'b1, 1'b0);
    run_random_stream(400);

    test_name = "drain";
    repeat (PIPE_DEPTH + 4) drive_cycle(random_pixel(), 1'b0, 1'b0);
    @(negedge video_clk_148);
    #1;

    if (active_checked >= MIN_ACTIVE)
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
    else
    begin
      $display("Too few active pixels reached the output: %0d", active_checked);
      $display("*** TEST FAILED ***");
      $fatal(1, "Run ended with a failure");
    end
  end

endmodule

/* sources.f */
+incdir+design
design/video_pkg.sv
design/video_delay_line.sv
design/rgb_to_ycbcr.sv
design/ycbcr_422_packer.sv
design/hdmi_ycbcr_top.sv
bench/tb_hdmi_ycbcr_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_hdmi_ycbcr_top \
  -f sources.f \
  -Mdir obj_dir

./obj_dir/Vtb_hdmi_ycbcr_top > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "Simulation failed"
  exit 1
fi

if ! grep -qF "*** TEST PASSED ***" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation passed"
